/* Makefile */
# Verilator build and run of the sound unit testbench

SOURCES := $(shell cat vlog.f)

obj_dir/VsoundTb: vlog.f $(SOURCES)
	verilator --binary --timing --assert --top-module soundTb -f vlog.f -o VsoundTb

run: obj_dir/VsoundTb
	./obj_dir/VsoundTb | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* verification/soundTb.sv */
/*
  Testbench for the two-channel sound unit
  - Clock, reset and Galois LFSR stimulus
  - Reference functions for samples, envelope, length and readback
  - Compare tasks and the sample checking process
  - Reset, readback, duty, envelope, length and credit tests
*/
`timescale 1ns/1ns
`default_nettype none

module soundTb import soundPkg::*; ();

	localparam int ResetCycles = 16;
	// Summed test lengths, doubled for margin
	localparam int TimeoutCycles =
		2 * (13 * EnvelopeTickCycles + 28 * LengthTickCycles + 80 * SamplePeriodCycles);

	logic    iClock;
	logic    rstN;
	logic    regWrite;
	regAddrT regAddr;
	regDataT regWriteData;
	regDataT regReadData;
	sampleT  sample;
	logic    sampleValid;
	logic    creditReturn = 1'b0;

	logic [31:0] lfsrState = 32'd84219;
	int   cycleCount  = 0;
	int   sampleCount = 0;
	int   outstanding = 0;
	int   failCount   = 0;
	// 0 off, 1 duty set, 2 envelope, 3 silence
	int   checkMode   = 0;
	int   allowVolume = 0;
	int   lastDistance = 0;
	int   envTriggerCycle = 0;
	int   distance;
	int   ticks;
	bit   seenHigh;
	bit   seenLow;
	bit   autoReturn = 1'b0;
	// Single credit handed back by the test sequence
	bit   returnPulse = 1'b0;

	soundTop dut (
		.iClock, .rstN, .regWrite, .regAddr, .regWriteData, .regReadData,
		.sample, .sampleValid, .creditReturn
	);

	initial iClock = 1'b0;
	always #4 iClock = ~iClock;

	////////////////////
	// Random numbers
	////////////////////
	// One LFSR step per bit taken
	function automatic int randomBits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsrState[0]);
			if (lfsrState[0]) begin
				lfsrState = (lfsrState >> 1) ^ 32'hA3000000;
			end else begin
				lfsrState = lfsrState >> 1;
			end
		end
		return value;
	endfunction

	////////////////////
	// Reference model
	////////////////////
	// Channel 1 silent at 15, channel 0 at 15 plus or minus volume
	function automatic bit sampleAllowed(input sampleT s, input int volume);
		return (int'(s) == 30 + volume) || (int'(s) == 30 - volume);
	endfunction

	// Period 1 envelope, one step per tick, clamped at the rails
	function automatic int envelopeVolume(input int start, input int tickCount, input bit up);
		int v;
		v = up ? start + tickCount : start - tickCount;
		if (v > 15) v = 15;
		if (v < 0) v = 0;
		return v;
	endfunction

	function automatic int lengthMinCycles(input int len);
		return (64 - len - 1) * LengthTickCycles;
	endfunction

	// Slack for first tick phase and sample slot
	function automatic int lengthMaxCycles(input int len);
		return (64 - len + 1) * LengthTickCycles + 2 * SamplePeriodCycles;
	endfunction

	// Trigger bit of offset 3 is never stored
	function automatic regDataT expectedRead(input int addr, input regDataT written);
		if (addr % 4 == 3) begin
			return written & 8'h7F;
		end
		return written;
	endfunction

	// Sample count as a credit value, pinned at the top of the range
	function automatic creditT countAsCredits(input int count);
		if (count >= (1 << $bits(creditT))) begin
			return '1;
		end
		return creditT'(count);
	endfunction

	////////////////////
	// Compare tasks
	////////////////////
	task automatic reportFailure();
		failCount++;
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkSample(input sampleT got, input sampleT expected, input string what);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s sample %0d, expected %0d",
				$time, what, got, expected);
			reportFailure();
		end
	endtask

	task automatic checkRead(input regDataT got, input regDataT expected, input int addr);
		if (got !== expected) begin
			$display("mismatch at %0t ns: register %0d read %h, expected %h",
				$time, addr, got, expected);
			reportFailure();
		end
	endtask

	task automatic checkCredits(input creditT got, input creditT expected);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %0d samples passed, expected %0d",
				$time, got, expected);
			reportFailure();
		end
	endtask

	////////////////////
	// Bus tasks
	////////////////////
	task automatic resetDut();
		autoReturn = 1'b0;
		checkMode  = 0;
		@(posedge iClock);
		rstN        <= 1'b0;
		regWrite    <= 1'b0;
		returnPulse <= 1'b0;
		repeat (ResetCycles) @(posedge iClock);
		rstN <= 1'b1;
	endtask

	task automatic writeRegister(input int addr, input regDataT data);
		@(posedge iClock);
		regWrite     <= 1'b1;
		regAddr      <= regAddrT'(addr);
		regWriteData <= data;
		@(posedge iClock);
		regWrite <= 1'b0;
	endtask

	// Readback is combinational, sampled one edge after the address
	task automatic readRegister(input int addr, output regDataT value);
		@(posedge iClock);
		regAddr <= regAddrT'(addr);
		@(posedge iClock);
		value = regReadData;
	endtask

	task automatic waitSamples(input int n);
		int target;
		target = sampleCount + n;
		while (sampleCount < target) @(posedge iClock);
	endtask

	// Auto mode hands back each credit one cycle after its sample
	always @(posedge iClock) begin
		if (autoReturn) begin
			creditReturn <= sampleValid;
		end else begin
			creditReturn <= returnPulse;
		end
	end

	////////////////////
	// Sample checking
	////////////////////
	// Negative edge, outputs are stable mid-cycle
	always @(negedge iClock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
			reportFailure();
		end
		if (!rstN) begin
			sampleCount = 0;
			outstanding = 0;
		end else begin
			outstanding = outstanding + int'(sampleValid) - int'(creditReturn);
			if (outstanding > SampleCredits || outstanding < 0) begin
				$display("credit error: %0d samples outstanding", outstanding);
				reportFailure();
			end
			if (sampleValid) begin
				sampleCount = sampleCount + 1;
				distance = (int'(sample) >= 30) ? int'(sample) - 30 : 30 - int'(sample);
				case (checkMode)
					1: begin
						if (!sampleAllowed(sample, allowVolume)) begin
							checkSample(sample, sampleT'(30 + allowVolume), "duty");
						end
						if (int'(sample) > 30) seenHigh = 1'b1;
						if (int'(sample) < 30) seenLow = 1'b1;
					end
					2: begin
						ticks = (cycleCount - envTriggerCycle) / EnvelopeTickCycles;
						// Never shrinks and moves one step at most
						if (distance < lastDistance || distance > lastDistance + 1) begin
							checkSample(sample, sampleT'(30 + lastDistance), "envelope step");
						end
						if (distance > envelopeVolume(3, ticks + 1, 1'b1) ||
							distance < envelopeVolume(3, ticks - 1, 1'b1)) begin
							checkSample(sample, sampleT'(30 + envelopeVolume(3, ticks, 1'b1)),
								"envelope tick");
						end
						lastDistance = distance;
					end
					3: checkSample(sample, sampleT'(30), "silence");
					default: ;
				endcase
			end
		end
	end

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		regDataT written [8];
		regDataT got;
		int volume;
		int freqOffset;
		int freq;
		int lengthLoad;
		int startCycle;
		int elapsed;
		int baseline;
		int gap;

		rstN         = 1'b0;
		regWrite     = 1'b0;
		regAddr      = '0;
		regWriteData = '0;

		// Reset and silence
		resetDut();
		autoReturn = 1'b1;
		checkMode  = 3;
		waitSamples(8);
		for (int a = 0; a <= 8; a++) begin
			readRegister(a, got);
			checkRead(got, 8'h00, a);
		end

		// Readback of random bytes, then trigger status
		resetDut();
		autoReturn = 1'b1;
		for (int a = 0; a < 8; a++) begin
			written[a] = regDataT'(randomBits(8));
			writeRegister(a, written[a]);
		end
		for (int a = 0; a < 8; a++) begin
			readRegister(a, got);
			checkRead(got, expectedRead(a, written[a]), a);
		end
		// Random bytes may have set a trigger, so status starts from reset
		resetDut();
		autoReturn = 1'b1;
		readRegister(8, got);
		checkRead(got, 8'h00, 8);
		writeRegister(3, (written[3] & 8'h3F) | 8'h80);
		readRegister(8, got);
		checkRead(got, 8'h01, 8);
		writeRegister(7, (written[7] & 8'h3F) | 8'h80);
		readRegister(8, got);
		checkRead(got, 8'h03, 8);

		// Duty 2 with a fixed volume on channel 0
		resetDut();
		autoReturn = 1'b1;
		volume     = 1 + randomBits(4) % 15;
		freqOffset = 8 + randomBits(5);
		freq       = 2048 - freqOffset;
		writeRegister(0, 8'h80);
		writeRegister(1, regDataT'(volume << 4));
		writeRegister(2, regDataT'(freq & 255));
		writeRegister(3, 8'h80 | regDataT'(freq >> 8));
		waitSamples(2);
		seenHigh    = 1'b0;
		seenLow     = 1'b0;
		allowVolume = volume;
		checkMode   = 1;
		// One waveform period is 8 timer reloads
		repeat (8 * freqOffset + 2 * SamplePeriodCycles) @(posedge iClock);
		if (!(seenHigh && seenLow)) begin
			$display("duty 2 waveform did not show both levels within one period");
			reportFailure();
		end

		// Envelope up from 3 with period 1
		resetDut();
		autoReturn = 1'b1;
		writeRegister(0, 8'h80);
		writeRegister(1, 8'h39);
		writeRegister(2, regDataT'(freq & 255));
		writeRegister(3, 8'h80 | regDataT'(freq >> 8));
		envTriggerCycle = cycleCount;
		waitSamples(2);
		lastDistance = 3;
		checkMode    = 2;
		while (lastDistance < 15) @(posedge iClock);
		repeat (2 * EnvelopeTickCycles) @(posedge iClock);
		checkMode = 0;

		// Timed length on channel 0
		resetDut();
		autoReturn = 1'b1;
		lengthLoad = 40 + randomBits(4);
		volume     = 1 + randomBits(4) % 15;
		writeRegister(0, 8'h80 | regDataT'(lengthLoad));
		writeRegister(1, regDataT'(volume << 4));
		writeRegister(2, regDataT'(freq & 255));
		writeRegister(3, 8'hC0 | regDataT'(freq >> 8));
		startCycle = cycleCount;
		do begin
			readRegister(8, got);
		end while (got[0]);
		elapsed = cycleCount - startCycle;
		if (elapsed < lengthMinCycles(lengthLoad) || elapsed > lengthMaxCycles(lengthLoad)) begin
			$display("mismatch at %0t ns: channel off after %0d cycles, expected %0d to %0d",
				$time, elapsed, lengthMinCycles(lengthLoad), lengthMaxCycles(lengthLoad));
			reportFailure();
		end
		waitSamples(2);
		checkMode = 3;
		waitSamples(4);
		checkMode = 0;

		// Untimed channel 1 outlives its length
		writeRegister(4, 8'h3F);
		writeRegister(5, 8'hF0);
		writeRegister(6, regDataT'(freq & 255));
		writeRegister(7, 8'h80 | regDataT'(freq >> 8));
		repeat (3 * LengthTickCycles) @(posedge iClock);
		readRegister(8, got);
		checkRead(got & 8'h02, 8'h02, 8);

		// Credit back-pressure
		resetDut();
		repeat (12 * SamplePeriodCycles) @(posedge iClock);
		checkCredits(countAsCredits(sampleCount), creditT'(SampleCredits));
		for (int k = 0; k < 5; k++) begin
			gap = 1 + randomBits(5);
			repeat (gap) @(posedge iClock);
			baseline = sampleCount;
			returnPulse <= 1'b1;
			@(posedge iClock);
			returnPulse <= 1'b0;
			repeat (3 * SamplePeriodCycles) @(posedge iClock);
			checkCredits(countAsCredits(sampleCount - baseline), creditT'(1));
		end

		if (failCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/soundTop_sva.sv */
/*
  Assertions bound to the sound unit top level
  - Sample only sent with credit available
  - Outstanding samples bounded by the credit depth
  - Quiet sample output after reset
*/
`timescale 1ns/1ns
`default_nettype none

module soundTop_sva import soundPkg::*; (
	input wire iClock,
	input wire rstN,
	input wire sampleValid,
	input wire creditReturn
);

	// Samples seen before this cycle minus credits returned
	logic [3:0] outstanding;

	always_ff @(posedge iClock) begin
		if (!rstN) begin
			outstanding <= '0;
		end else begin
			outstanding <= outstanding + 4'(sampleValid) - 4'(creditReturn);
		end
	end

	////////////////////
	// Credit handshake
	////////////////////
	validNeedsCredit: assert property (@(posedge iClock) disable iff (!rstN)
		sampleValid |-> outstanding < 4'(SampleCredits))
		else $error("sample sent without credit");

	outstandingBounded: assert property (@(posedge iClock) disable iff (!rstN)
		outstanding <= 4'(SampleCredits))
		else $error("outstanding samples above credit depth");

	// Reset state
	quietAfterReset: assert property (@(posedge iClock) !rstN |=> !sampleValid)
		else $error("sampleValid high right after reset");

endmodule

bind soundTop soundTop_sva sva (
	.iClock(iClock),
	.rstN(rstN),
	.sampleValid(sampleValid),
	.creditReturn(creditReturn)
);

`default_nettype wire

/* verilog/frameSequencer.sv */
/*
  Frame sequencer
  - Free-running clock divider
  - Length tick strobe every LengthTickCycles
  - Envelope tick strobe every EnvelopeTickCycles, on every fourth length tick
*/
`timescale 1ns/1ns
`default_nettype none

module frameSequencer import soundPkg::*; (
	input  wire  iClock,
	input  wire  rstN,
	output logic lengthTick,
	output logic envelopeTick
);

	logic [SeqCountBits-1:0] divCount;

	// Single divider for both strobes
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			divCount <= '0;
		end else begin
			divCount <= divCount + 1'b1;
		end
	end

	////////////////////
	// Strobes
	////////////////////
	// Low bits all ones marks a length tick
	assign lengthTick =
		divCount[LengthCountBits-1:0] == LengthCountBits'(LengthTickCycles - 1);

	// Full count all ones, so it lines up with a length tick
	assign envelopeTick = divCount == SeqCountBits'(EnvelopeTickCycles - 1);

endmodule

`default_nettype wire

/* verilog/sampleMixer.sv */
/*
  Sample mixer
  - Sample slot divider
  - Two-channel level sum
  - Credit counter for the sample output
*/
`timescale 1ns/1ns
`default_nettype none

module sampleMixer import soundPkg::*; (
	input  wire    iClock,
	input  wire    rstN,
	input  levelT  level0,
	input  levelT  level1,
	input  wire    creditReturn,
	output sampleT sample,
	output logic   sampleValid
);

	logic [SlotCountBits-1:0] slotCount;
	logic                     slot;
	creditT                   credits;
	logic                     sendNow;

	////////////////////
	// Slot divider
	////////////////////
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			slotCount <= '0;
		end else begin
			slotCount <= slotCount + 1'b1;
		end
	end

	// Last count of each period is the slot
	assign slot = slotCount == SlotCountBits'(SamplePeriodCycles - 1);

	// A return in this same cycle counts as credit
	assign sendNow = slot && ((credits != '0) || creditReturn);

	////////////////////
	// Credits
	////////////////////
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			credits <= creditT'(SampleCredits);
		end else begin
			// Returns in, sends out, both in one cycle
			credits <= credits + creditT'(creditReturn) - creditT'(sendNow);
		end
	end

	// Valid strobe, one cycle per sent sample
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			sampleValid <= 1'b0;
		end else begin
			sampleValid <= sendNow;
		end
	end

	// Sum captured only on a sent slot
	// Dropped slots leave the old value
	always_ff @(posedge iClock) begin
		if (sendNow) begin
			sample <= sampleT'(level0) + sampleT'(level1);
		end
	end

endmodule

`default_nettype wire

/* verilog/soundPkg.sv */
/*
  Shared definitions for the two-channel square-wave sound unit
  - Vector typedefs for register, channel and sample widths
  - Envelope FSM state encoding
  - Prescaler and sample-rate periods, credit depth
  - Register map addresses and field offsets
*/
`default_nettype none

package soundPkg;

	////////////////////
	// Vector types
	////////////////////
	typedef logic [3:0]  regAddrT;
	typedef logic [7:0]  regDataT;
	typedef logic [10:0] freqT;
	typedef logic [3:0]  volumeT;
	typedef logic [5:0]  lengthT;
	typedef logic [1:0]  dutyT;
	typedef logic [2:0]  envPeriodT;
	// Biased level, 15 sits in the middle
	typedef logic [4:0]  levelT;
	typedef logic [5:0]  sampleT;
	typedef logic [2:0]  creditT;

	// Envelope FSM
	typedef enum logic [1:0] {
		envIdle,
		envCount,
		envHold
	} envStateT;

	////////////////////
	// Timing
	////////////////////
	// Scaled down so simulation stays short
	localparam int LengthTickCycles   = 64;
	localparam int EnvelopeTickCycles = 256;
	localparam int SamplePeriodCycles = 16;
	localparam int SampleCredits      = 4;
	localparam int SilentLevel        = 15;

	// Counter widths derived from the periods
	localparam int LengthCountBits = $clog2(LengthTickCycles);
	localparam int SeqCountBits    = $clog2(EnvelopeTickCycles);
	localparam int SlotCountBits   = $clog2(SamplePeriodCycles);

	////////////////////
	// Register map
	////////////////////
	localparam int ChannelBytes     = 8;
	localparam int Ch0Base          = 0;
	localparam int Ch1Base          = 4;
	// Per-channel offsets
	localparam int OffsetDutyLength = 0;
	localparam int OffsetEnvelope   = 1;
	localparam int OffsetFreqLow    = 2;
	localparam int OffsetFreqHigh   = 3;
	localparam regAddrT AddrStatus  = 4'd8;

endpackage

`default_nettype wire

/* verilog/soundRegisters.sv */
/*
  Register file for the sound unit
  - Eight channel bytes, four per channel
  - Field decode into typed channel settings
  - One-cycle trigger pulse per channel
  - Combinational readback with status at address 8
*/
`timescale 1ns/1ns
`default_nettype none

module soundRegisters import soundPkg::*; (
	input  wire        iClock,
	input  wire        rstN,
	input  wire        regWrite,
	input  regAddrT    regAddr,
	input  regDataT    regWriteData,
	input  wire  [1:0] channelOn,
	output regDataT    regReadData,
	// Channel 0 settings
	output dutyT       duty_0,
	output lengthT     length_0,
	output volumeT     initVolume_0,
	output logic       envUp_0,
	output envPeriodT  envPeriod_0,
	output freqT       freq_0,
	output logic       timed_0,
	output logic       trigger_0,
	// Channel 1 settings
	output dutyT       duty_1,
	output lengthT     length_1,
	output volumeT     initVolume_1,
	output logic       envUp_1,
	output envPeriodT  envPeriod_1,
	output freqT       freq_1,
	output logic       timed_1,
	output logic       trigger_1
);

	regDataT chanBytes [ChannelBytes];
	logic    chanSelect;
	logic    isHighByte;
	logic    isTrigger;

	// Address decode
	assign chanSelect = regAddr < regAddrT'(ChannelBytes);
	assign isHighByte = regAddr[1:0] == 2'(OffsetFreqHigh);
	// Trigger bit only acts, never stored
	assign isTrigger  = regWrite && chanSelect && isHighByte && regWriteData[7];

	////////////////////
	// Byte storage
	////////////////////
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			for (int i = 0; i < ChannelBytes; i++) begin
				chanBytes[i] <= '0;
			end
		end else if (regWrite && chanSelect) begin
			// Bit 7 of the high byte reads back clear
			if (isHighByte) begin
				chanBytes[regAddr[2:0]] <= {1'b0, regWriteData[6:0]};
			end else begin
				chanBytes[regAddr[2:0]] <= regWriteData;
			end
		end
	end

	// Trigger pulses, one cycle after the write edge
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			trigger_0 <= 1'b0;
			trigger_1 <= 1'b0;
		end else begin
			trigger_0 <= isTrigger && (regAddr < regAddrT'(Ch1Base));
			trigger_1 <= isTrigger && (regAddr >= regAddrT'(Ch1Base));
		end
	end

	////////////////////
	// Field decode
	////////////////////
	// Duty and length
	assign duty_0       = chanBytes[Ch0Base + OffsetDutyLength][7:6];
	assign length_0     = chanBytes[Ch0Base + OffsetDutyLength][5:0];
	assign duty_1       = chanBytes[Ch1Base + OffsetDutyLength][7:6];
	assign length_1     = chanBytes[Ch1Base + OffsetDutyLength][5:0];

	// Envelope volume, direction, period
	assign initVolume_0 = chanBytes[Ch0Base + OffsetEnvelope][7:4];
	assign envUp_0      = chanBytes[Ch0Base + OffsetEnvelope][3];
	assign envPeriod_0  = chanBytes[Ch0Base + OffsetEnvelope][2:0];
	assign initVolume_1 = chanBytes[Ch1Base + OffsetEnvelope][7:4];
	assign envUp_1      = chanBytes[Ch1Base + OffsetEnvelope][3];
	assign envPeriod_1  = chanBytes[Ch1Base + OffsetEnvelope][2:0];

	// Frequency spans low byte and three high bits
	assign freq_0  = {chanBytes[Ch0Base + OffsetFreqHigh][2:0], chanBytes[Ch0Base + OffsetFreqLow]};
	assign freq_1  = {chanBytes[Ch1Base + OffsetFreqHigh][2:0], chanBytes[Ch1Base + OffsetFreqLow]};
	assign timed_0 = chanBytes[Ch0Base + OffsetFreqHigh][6];
	assign timed_1 = chanBytes[Ch1Base + OffsetFreqHigh][6];

	////////////////////
	// Readback
	////////////////////
	always_comb begin
		if (chanSelect) begin
			regReadData = chanBytes[regAddr[2:0]];
		end else if (regAddr == AddrStatus) begin
			regReadData = {6'b0, channelOn};
		end else begin
			regReadData = '0;
		end
	end

endmodule

`default_nettype wire

/* verilog/soundTop.sv */
/*
  Sound unit top level
  - Register file and frame sequencer
  - Two square channels
  - Sample mixer with credit output
*/
`timescale 1ns/1ns
`default_nettype none

module soundTop import soundPkg::*; (
	input  wire     iClock,
	input  wire     rstN,
	// Register port
	input  wire     regWrite,
	input  regAddrT regAddr,
	input  regDataT regWriteData,
	output regDataT regReadData,
	// Sample port
	output sampleT  sample,
	output logic    sampleValid,
	input  wire     creditReturn
);

	dutyT      duty0, duty1;
	lengthT    length0, length1;
	volumeT    initVolume0, initVolume1;
	logic      envUp0, envUp1;
	envPeriodT envPeriod0, envPeriod1;
	freqT      freq0, freq1;
	logic      timed0, timed1;
	logic      trigger0, trigger1;
	logic      lengthTick, envelopeTick;
	levelT     level0, level1;
	logic      channelOn0, channelOn1;

	soundRegisters registers (
		.iClock, .rstN, .regWrite, .regAddr, .regWriteData, .regReadData,
		.channelOn    ({channelOn1, channelOn0}),
		.duty_0       (duty0),       .length_0   (length0),
		.initVolume_0 (initVolume0), .envUp_0    (envUp0),
		.envPeriod_0  (envPeriod0),  .freq_0     (freq0),
		.timed_0      (timed0),      .trigger_0  (trigger0),
		.duty_1       (duty1),       .length_1   (length1),
		.initVolume_1 (initVolume1), .envUp_1    (envUp1),
		.envPeriod_1  (envPeriod1),  .freq_1     (freq1),
		.timed_1      (timed1),      .trigger_1  (trigger1)
	);

	// Shared tick strobes
	frameSequencer sequencer (.iClock, .rstN, .lengthTick, .envelopeTick);

	////////////////////
	// Channels
	////////////////////
	squareChannel channel0 (
		.iClock, .rstN, .trigger(trigger0), .duty(duty0), .length(length0),
		.initVolume(initVolume0), .envUp(envUp0), .envPeriod(envPeriod0),
		.freq(freq0), .timed(timed0), .lengthTick, .envelopeTick,
		.level(level0), .channelOn(channelOn0)
	);

	squareChannel channel1 (
		.iClock, .rstN, .trigger(trigger1), .duty(duty1), .length(length1),
		.initVolume(initVolume1), .envUp(envUp1), .envPeriod(envPeriod1),
		.freq(freq1), .timed(timed1), .lengthTick, .envelopeTick,
		.level(level1), .channelOn(channelOn1)
	);

	// Mix and credit output
	sampleMixer mixer (
		.iClock, .rstN, .level0, .level1, .creditReturn, .sample, .sampleValid
	);

endmodule

`default_nettype wire

/* verilog/squareChannel.sv */
/*
  Square-wave channel
  - Frequency timer and 8-step duty position
  - Duty pattern select
  - Volume envelope FSM
  - Length counter for timed mode
  - Biased output level, SilentLevel when off
*/
`timescale 1ns/1ns
`default_nettype none

module squareChannel import soundPkg::*; (
	input  wire        iClock,
	input  wire        rstN,
	input  wire        trigger,
	input  dutyT       duty,
	input  lengthT     length,
	input  volumeT     initVolume,
	input  wire        envUp,
	input  envPeriodT  envPeriod,
	input  freqT       freq,
	input  wire        timed,
	input  wire        lengthTick,
	input  wire        envelopeTick,
	output levelT      level,
	output logic       channelOn
);

	logic [11:0] freqTimer;
	logic [11:0] freqReload;
	logic [2:0]  dutyPos;
	logic        dutyHigh;
	envStateT    envState;
	envPeriodT   envCounter;
	volumeT      volume;
	logic        envAtLimit;
	logic [6:0]  lengthCount;

	// 2048 minus freq, so range is 1 to 2048
	assign freqReload = 12'd2048 - {1'b0, freq};

	////////////////////
	// Frequency timer
	////////////////////
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			freqTimer <= '0;
			dutyPos   <= '0;
		end else if (trigger) begin
			freqTimer <= freqReload;
			dutyPos   <= '0;
		end else if (freqTimer <= 12'd1) begin
			// Expiry, step the waveform
			freqTimer <= freqReload;
			dutyPos   <= dutyPos + 1'b1;
		end else begin
			freqTimer <= freqTimer - 1'b1;
		end
	end

	// Duty patterns over positions 0..7
	always_comb begin
		case (duty)
			2'd0:    dutyHigh = dutyPos == 3'd7;
			2'd1:    dutyHigh = dutyPos >= 3'd6;
			2'd2:    dutyHigh = dutyPos >= 3'd4;
			default: dutyHigh = dutyPos <= 3'd5;
		endcase
	end

	////////////////////
	// Envelope
	////////////////////
	// Top or bottom reached in the current direction
	assign envAtLimit = envUp ? (volume == 4'd15) : (volume == 4'd0);

	always_ff @(posedge iClock) begin
		if (!rstN) begin
			envState   <= envIdle;
			envCounter <= '0;
			volume     <= '0;
		end else if (trigger) begin
			volume     <= initVolume;
			envCounter <= '0;
			envState   <= (envPeriod == '0) ? envIdle : envCount;
		end else begin
			case (envState)
				envCount: begin
					if (envPeriod == '0) begin
						envState <= envIdle;
					end else if (envelopeTick) begin
						if (envCounter == envPeriod - 1'b1) begin
							envCounter <= '0;
							// Step once per period, stop at the rail
							if (envAtLimit) begin
								envState <= envHold;
							end else if (envUp) begin
								volume <= volume + 1'b1;
							end else begin
								volume <= volume - 1'b1;
							end
						end else begin
							envCounter <= envCounter + 1'b1;
						end
					end
				end
				// Idle and hold keep the volume until next trigger
				default: envState <= envState;
			endcase
		end
	end

	////////////////////
	// Length counter
	////////////////////
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			lengthCount <= '0;
			channelOn   <= 1'b0;
		end else if (trigger) begin
			lengthCount <= 7'd64 - {1'b0, length};
			channelOn   <= 1'b1;
		end else if (timed && channelOn && lengthTick) begin
			// Last tick turns the channel off
			if (lengthCount <= 7'd1) begin
				lengthCount <= '0;
				channelOn   <= 1'b0;
			end else begin
				lengthCount <= lengthCount - 1'b1;
			end
		end
	end

	// Output remap around the silent level
	always_ff @(posedge iClock) begin
		if (!rstN) begin
			level <= levelT'(SilentLevel);
		end else if (!channelOn) begin
			level <= levelT'(SilentLevel);
		end else if (dutyHigh) begin
			level <= levelT'(SilentLevel) + {1'b0, volume};
		end else begin
			level <= levelT'(SilentLevel) - {1'b0, volume};
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
verilog/soundPkg.sv
verilog/soundRegisters.sv
verilog/frameSequencer.sv
verilog/squareChannel.sv
verilog/sampleMixer.sv
verilog/soundTop.sv
verification/soundTop_sva.sv
verification/soundTb.sv
